// File: logic/trig_settings.svh
`ifndef TRIG_SETTINGS_SVH
`define TRIG_SETTINGS_SVH

// front-end inputs
`define TRIG_NSURF 8
`define TRIG_WORD_W 16

// command frame and the two trigger word sample points after the phase pulse
`define TRIG_FRAME 8
`define TRIG_SAMPLE_A 2
`define TRIG_SAMPLE_B 6

`define TRIG_DEFAULT_HOLDOFF 16'd20
`define TRIG_REG_AW 10

`endif

// File: logic/trig_pkg.sv
`default_nettype none
`include "trig_settings.svh"

package trig_pkg;

    // opcode in the top nibble of the command word
    typedef enum logic [3:0] {
        CMD_IDLE    = 4'd0,
        CMD_TRIG    = 4'd1,
        CMD_RUNRST  = 4'd2,
        CMD_RUNSTOP = 4'd3
    } cmd_op_e;

    // register blocks, selected by the top two address bits
    typedef enum logic [1:0] {
        BLK_CMD     = 2'd0,
        BLK_TRIGCTL = 2'd1,
        BLK_RSVD    = 2'd2,
        BLK_SCALER  = 2'd3
    } reg_block_e;

    // command word, msb first
    typedef struct packed {
        cmd_op_e     op;
        logic [7:0]  metadata;
        logic [11:0] count;
        logic [7:0]  srcmap;
    } cmd_word_t;

    // event source map: one bit per SURF, soft trigger on top
    localparam int NSRC     = `TRIG_NSURF + 1;
    localparam int SRC_SOFT = `TRIG_NSURF;

    // trigger control block addresses
    localparam logic [7:0] TRIGCTL_MASK    = 8'd0;
    localparam logic [7:0] TRIGCTL_HOLDOFF = 8'd1;
    localparam logic [7:0] TRIGCTL_SOFT    = 8'd2;
    localparam logic [7:0] TRIGCTL_COUNT   = 8'd3;

endpackage

`default_nettype wire

// File: logic/reg_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

// one 256-word register block
interface reg_bus_if;
    logic [7:0]  adr;
    logic [31:0] wdat;
    logic        we;
    logic        stb;
    logic [31:0] rdat;
    logic        ack;

    modport host (output adr, wdat, we, stb, input rdat, ack);
    // target acks one cycle after stb, rdat valid with ack
    modport target (input adr, wdat, we, stb, output rdat, ack);
endinterface

// accepted trigger record, valid is a single-cycle pulse
interface trig_evt_if;
    logic                      valid;
    logic [trig_pkg::NSRC-1:0] srcmap;
    logic [7:0]                metadata;
    logic [15:0]               count;

    modport src (output valid, srcmap, metadata, count);
    modport snk (input valid, srcmap, metadata, count);
endinterface

`default_nettype wire

// File: logic/trig_ctrl_regs.sv
`timescale 1ns/10ps
`default_nettype none
`include "trig_settings.svh"

module trig_ctrl_regs (
    input  wire                    sysclk_i,
    input  wire                    rst_n_i,
    reg_bus_if.target              bus_i,
    input  wire [15:0]             count_i,
    output logic [`TRIG_NSURF-1:0] trig_mask_o,
    output logic [15:0]            trig_holdoff_o,
    output logic                   soft_valid_o,
    output logic [7:0]             soft_metadata_o
);

    logic wr_stb;
    logic soft_wr;

    assign wr_stb  = bus_i.stb && bus_i.we;
    assign soft_wr = wr_stb && (bus_i.adr == trig_pkg::TRIGCTL_SOFT);

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus_i.ack      <= 1'b0;
            trig_mask_o    <= '0;
            trig_holdoff_o <= `TRIG_DEFAULT_HOLDOFF;
            soft_valid_o   <= 1'b0;
        end else begin
            bus_i.ack <= bus_i.stb;
            // soft trigger request goes out alongside the ack
            soft_valid_o <= soft_wr;
            if (wr_stb && (bus_i.adr == trig_pkg::TRIGCTL_MASK)) begin
                trig_mask_o <= bus_i.wdat[`TRIG_NSURF-1:0];
            end
            if (wr_stb && (bus_i.adr == trig_pkg::TRIGCTL_HOLDOFF)) begin
                trig_holdoff_o <= bus_i.wdat[15:0];
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (soft_wr) begin
            soft_metadata_o <= bus_i.wdat[7:0];
        end
        if (bus_i.stb) begin
            case (bus_i.adr)
                trig_pkg::TRIGCTL_MASK:    bus_i.rdat <= 32'(trig_mask_o);
                trig_pkg::TRIGCTL_HOLDOFF: bus_i.rdat <= 32'(trig_holdoff_o);
                trig_pkg::TRIGCTL_SOFT:    bus_i.rdat <= 32'(soft_metadata_o);
                trig_pkg::TRIGCTL_COUNT:   bus_i.rdat <= 32'(count_i);
                default:                   bus_i.rdat <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/trig_master.sv
`timescale 1ns/10ps
`default_nettype none
`include "trig_settings.svh"

module trig_master (
    input  wire                                       sysclk_i,
    input  wire                                       rst_n_i,
    input  wire                                       sysclk_phase_i,
    input  wire [`TRIG_NSURF-1:0][`TRIG_WORD_W-1:0]   trig_dat_i,
    input  wire [`TRIG_NSURF-1:0]                     trig_mask_i,
    input  wire [15:0]                                trig_holdoff_i,
    input  wire                                       soft_valid_i,
    input  wire [7:0]                                 soft_metadata_i,
    input  wire                                       running_i,
    output logic                                      event_o,
    trig_evt_if.src                                   evt_o
);

    localparam int PHASE_W = $clog2(`TRIG_FRAME);

    logic [PHASE_W-1:0]        phase_cnt;
    logic                      sample;
    logic                      soft_pend;
    logic [15:0]               holdoff_cnt;
    logic                      running_q;
    logic                      run_start;
    logic [`TRIG_NSURF-1:0]    surf_req;
    logic [trig_pkg::NSRC-1:0] req_map;
    logic [7:0]                req_meta;
    logic                      accept;
    logic                      valid_q;
    logic [15:0]               count_q;
    logic [trig_pkg::NSRC-1:0] srcmap_q;
    logic [7:0]                meta_q;

    // phase_cnt reads 1 in the cycle after the phase pulse
    assign sample = (phase_cnt == PHASE_W'(`TRIG_SAMPLE_A)) ||
                    (phase_cnt == PHASE_W'(`TRIG_SAMPLE_B));

    // a set mask bit disables that SURF
    // descending loop so the lowest requester supplies the metadata
    always_comb begin
        surf_req = '0;
        req_meta = soft_metadata_i;
        for (int i = `TRIG_NSURF - 1; i >= 0; i--) begin
            surf_req[i] = trig_dat_i[i][`TRIG_WORD_W-1] && !trig_mask_i[i];
            if (surf_req[i]) begin
                req_meta = trig_dat_i[i][7:0];
            end
        end
    end

    assign req_map   = {soft_pend, surf_req};
    assign accept    = sample && running_i && (holdoff_cnt == 16'd0) && (|req_map);
    assign run_start = running_i && !running_q;

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_cnt   <= '0;
            soft_pend   <= 1'b0;
            holdoff_cnt <= '0;
            running_q   <= 1'b0;
            valid_q     <= 1'b0;
            count_q     <= '0;
        end else begin
            if (sysclk_phase_i) begin
                phase_cnt <= PHASE_W'(1);
            end else begin
                phase_cnt <= phase_cnt + PHASE_W'(1);
            end
            // soft request lives until the next sample point, served or not
            if (soft_valid_i) begin
                soft_pend <= 1'b1;
            end else if (sample) begin
                soft_pend <= 1'b0;
            end
            if (accept) begin
                holdoff_cnt <= trig_holdoff_i;
            end else if (holdoff_cnt != 16'd0) begin
                holdoff_cnt <= holdoff_cnt - 16'd1;
            end
            running_q <= running_i;
            valid_q   <= accept;
            // run-reset shows up here as the start of running
            if (run_start) begin
                count_q <= {15'd0, accept};
            end else if (accept) begin
                count_q <= count_q + 16'd1;
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (accept) begin
            srcmap_q <= req_map;
            meta_q   <= req_meta;
        end
    end

    assign event_o         = valid_q;
    assign evt_o.valid     = valid_q;
    assign evt_o.srcmap    = srcmap_q;
    assign evt_o.metadata  = meta_q;
    assign evt_o.count     = count_q;

endmodule

`default_nettype wire

// File: logic/trig_command.sv
`timescale 1ns/10ps
`default_nettype none

module trig_command (
    input  wire         sysclk_i,
    input  wire         rst_n_i,
    input  wire         sysclk_phase_i,
    reg_bus_if.target   bus_i,
    trig_evt_if.snk     evt_i,
    output logic        runrst_o,
    output logic        running_o,
    output logic [31:0] command_o
);

    logic                      cmd_wr;
    logic                      runrst_wr;
    logic                      runstop_wr;
    logic                      runrst_pend;
    logic                      runstop_pend;
    logic                      trig_pend;
    logic                      running_q;
    logic                      frame;
    logic [trig_pkg::NSRC-1:0] evt_srcmap;
    logic [7:0]                evt_meta;
    logic [15:0]               evt_count;
    trig_pkg::cmd_word_t       cmd_next;
    trig_pkg::cmd_word_t       cmd_q;

    assign cmd_wr = bus_i.stb && bus_i.we && (bus_i.adr == 8'd0);
    assign frame  = sysclk_phase_i;

    // highest priority pending request wins the frame
    always_comb begin
        cmd_next    = '0;
        cmd_next.op = trig_pkg::CMD_IDLE;
        if (runrst_pend) begin
            cmd_next.op = trig_pkg::CMD_RUNRST;
        end else if (runstop_pend) begin
            cmd_next.op = trig_pkg::CMD_RUNSTOP;
        end else if (trig_pend) begin
            cmd_next.op       = trig_pkg::CMD_TRIG;
            cmd_next.metadata = evt_meta;
            cmd_next.count    = evt_count[11:0];
            // soft source folds into bit 7
            cmd_next.srcmap   = evt_srcmap[7:0] | {evt_srcmap[trig_pkg::SRC_SOFT], 7'd0};
        end
    end

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus_i.ack    <= 1'b0;
            runrst_wr    <= 1'b0;
            runstop_wr   <= 1'b0;
            runrst_o     <= 1'b0;
            running_q    <= 1'b0;
            runrst_pend  <= 1'b0;
            runstop_pend <= 1'b0;
            trig_pend    <= 1'b0;
            cmd_q        <= '0;
        end else begin
            bus_i.ack  <= bus_i.stb;
            runrst_wr  <= cmd_wr && bus_i.wdat[0];
            runstop_wr <= cmd_wr && bus_i.wdat[1];
            // one cycle after the write ack
            runrst_o   <= runrst_wr;
            if (runstop_wr) begin
                running_q <= 1'b0;
            end else if (runrst_wr) begin
                running_q <= 1'b1;
            end
            // new requests arriving in the frame cycle wait for the next frame
            runrst_pend  <= runrst_wr ||
                            (runrst_pend && !(frame && cmd_next.op == trig_pkg::CMD_RUNRST));
            runstop_pend <= runstop_wr ||
                            (runstop_pend && !(frame && cmd_next.op == trig_pkg::CMD_RUNSTOP));
            trig_pend    <= evt_i.valid ||
                            (trig_pend && !(frame && cmd_next.op == trig_pkg::CMD_TRIG));
            if (frame) begin
                cmd_q <= cmd_next;
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (evt_i.valid) begin
            evt_srcmap <= evt_i.srcmap;
            evt_meta   <= evt_i.metadata;
            evt_count  <= evt_i.count;
        end
        if (bus_i.stb) begin
            bus_i.rdat <= (bus_i.adr == 8'd0) ? {31'd0, running_q} : 32'd0;
        end
    end

    assign running_o = running_q;
    assign command_o = cmd_q;

endmodule

`default_nettype wire

// File: logic/trig_scalers.sv
`timescale 1ns/10ps
`default_nettype none

module trig_scalers (
    input  wire       sysclk_i,
    input  wire       rst_n_i,
    input  wire       pps_i,
    reg_bus_if.target bus_i,
    trig_evt_if.snk   evt_i
);

    localparam int NSRC = trig_pkg::NSRC;

    logic            pps_q;
    logic            pps_rise;
    logic [NSRC-1:0] hit;
    logic [15:0]     live_cnt [NSRC];
    logic [15:0]     latch_cnt [NSRC];

    assign pps_rise = pps_i && !pps_q;
    assign hit      = evt_i.valid ? evt_i.srcmap : '0;

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus_i.ack <= 1'b0;
            pps_q     <= 1'b0;
            for (int i = 0; i < NSRC; i++) begin
                live_cnt[i]  <= '0;
                latch_cnt[i] <= '0;
            end
        end else begin
            bus_i.ack <= bus_i.stb;
            pps_q     <= pps_i;
            for (int i = 0; i < NSRC; i++) begin
                if (pps_rise) begin
                    // a hit in the pps cycle counts toward the new second
                    latch_cnt[i] <= live_cnt[i];
                    live_cnt[i]  <= {15'd0, hit[i]};
                end else if (hit[i] && (live_cnt[i] != 16'hffff)) begin
                    live_cnt[i] <= live_cnt[i] + 16'd1;
                end
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (bus_i.stb) begin
            if (bus_i.adr < 8'(NSRC)) begin
                bus_i.rdat <= 32'(latch_cnt[bus_i.adr[3:0]]);
            end else begin
                bus_i.rdat <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/trig_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "trig_settings.svh"

module trig_top (
    input  wire                                     sysclk_i,
    input  wire                                     rst_n_i,
    input  wire                                     sysclk_phase_i,
    input  wire                                     pps_i,
    input  wire [`TRIG_NSURF-1:0][`TRIG_WORD_W-1:0] trig_dat_i,
    input  wire [`TRIG_REG_AW-1:0]                  reg_adr_i,
    input  wire [31:0]                              reg_dat_i,
    input  wire                                     reg_we_i,
    input  wire                                     reg_stb_i,
    output logic [31:0]                             reg_dat_o,
    output logic                                    reg_ack_o,
    output logic                                    runrst_o,
    output logic                                    event_o,
    output logic [31:0]                             command_o
);

    localparam int IDX_CMD     = int'(trig_pkg::BLK_CMD);
    localparam int IDX_TRIGCTL = int'(trig_pkg::BLK_TRIGCTL);
    localparam int IDX_RSVD    = int'(trig_pkg::BLK_RSVD);
    localparam int IDX_SCALER  = int'(trig_pkg::BLK_SCALER);

    trig_pkg::reg_block_e   blk;
    logic [3:0]             ack_vec;
    logic [31:0]            dat_vec [4];
    logic [`TRIG_NSURF-1:0] trig_mask;
    logic [15:0]            trig_holdoff;
    logic                   soft_valid;
    logic [7:0]             soft_metadata;
    logic                   running;

    reg_bus_if  bus [4] ();
    trig_evt_if evt ();

    assign blk = trig_pkg::reg_block_e'(reg_adr_i[`TRIG_REG_AW-1 -: 2]);

    // only the addressed block sees the strobe
    for (genvar b = 0; b < 4; b++) begin : g_blk
        assign bus[b].adr  = reg_adr_i[7:0];
        assign bus[b].wdat = reg_dat_i;
        assign bus[b].we   = reg_we_i;
        assign bus[b].stb  = reg_stb_i && (blk == trig_pkg::reg_block_e'(b));
        assign ack_vec[b]  = bus[b].ack;
        assign dat_vec[b]  = bus[b].rdat;
    end

    // reserved block acks and reads zero
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus[IDX_RSVD].ack <= 1'b0;
        end else begin
            bus[IDX_RSVD].ack <= bus[IDX_RSVD].stb;
        end
    end
    assign bus[IDX_RSVD].rdat = '0;

    // select by whichever block is acking
    always_comb begin
        reg_dat_o = '0;
        for (int b = 0; b < 4; b++) begin
            if (ack_vec[b]) begin
                reg_dat_o = dat_vec[b];
            end
        end
    end
    assign reg_ack_o = |ack_vec;

    trig_ctrl_regs u_ctrl (
        .sysclk_i        (sysclk_i),
        .rst_n_i         (rst_n_i),
        .bus_i           (bus[IDX_TRIGCTL]),
        .count_i         (evt.count),
        .trig_mask_o     (trig_mask),
        .trig_holdoff_o  (trig_holdoff),
        .soft_valid_o    (soft_valid),
        .soft_metadata_o (soft_metadata)
    );

    trig_master u_master (
        .sysclk_i        (sysclk_i),
        .rst_n_i         (rst_n_i),
        .sysclk_phase_i  (sysclk_phase_i),
        .trig_dat_i      (trig_dat_i),
        .trig_mask_i     (trig_mask),
        .trig_holdoff_i  (trig_holdoff),
        .soft_valid_i    (soft_valid),
        .soft_metadata_i (soft_metadata),
        .running_i       (running),
        .event_o         (event_o),
        .evt_o           (evt)
    );

    trig_command u_command (
        .sysclk_i       (sysclk_i),
        .rst_n_i        (rst_n_i),
        .sysclk_phase_i (sysclk_phase_i),
        .bus_i          (bus[IDX_CMD]),
        .evt_i          (evt),
        .runrst_o       (runrst_o),
        .running_o      (running),
        .command_o      (command_o)
    );

    trig_scalers u_scalers (
        .sysclk_i (sysclk_i),
        .rst_n_i  (rst_n_i),
        .pps_i    (pps_i),
        .bus_i    (bus[IDX_SCALER]),
        .evt_i    (evt)
    );

endmodule

`default_nettype wire

// File: testbench/trig_top_tb.sv
`timescale 1ns/10ps
`default_nettype none

module trig_top_tb;

    localparam int TIMEOUT_CYCLES = 6000;
    localparam logic [3:0] OP_TRIG    = trig_pkg::CMD_TRIG;
    localparam logic [3:0] OP_RUNRST  = trig_pkg::CMD_RUNRST;
    localparam logic [3:0] OP_RUNSTOP = trig_pkg::CMD_RUNSTOP;

    logic             sysclk_i;
    logic             rst_n_i;
    logic             sysclk_phase_i;
    logic             pps_i;
    logic [7:0][15:0] trig_dat_i;
    logic [9:0]       reg_adr_i;
    logic [31:0]      reg_dat_i;
    logic             reg_we_i;
    logic             reg_stb_i;
    logic [31:0]      reg_dat_o;
    logic             reg_ack_o;
    logic             runrst_o;
    logic             event_o;
    logic [31:0]      command_o;

    // stimulus control and the write currently on the bus
    logic        surf_en;
    int          req_pct;
    logic        wr_pend;
    logic [9:0]  wr_adr;
    logic [31:0] wr_dat;

    // reference model state, one step per clock cycle
    int          mdl_since = 100;
    logic        mdl_valid = 1'b0;
    logic [8:0]  mdl_srcmap = '0;
    logic [7:0]  mdl_meta = '0;
    logic [15:0] mdl_count = '0;
    logic [15:0] mdl_hold = '0;
    logic [15:0] mdl_holdoff = 16'd20;
    logic [7:0]  mdl_mask = '0;
    logic        mdl_running = 1'b0;
    logic        mdl_runrst = 1'b0;
    logic        mdl_soft_pend = 1'b0;
    logic [7:0]  mdl_soft_meta = '0;
    logic [1:0]  cmd_d1 = '0;
    logic        soft_d1 = 1'b0;
    logic [7:0]  soft_meta_d1 = '0;
    logic        mdl_runrst_pend = 1'b0;
    logic        mdl_runstop_pend = 1'b0;
    logic        mdl_trig_pend = 1'b0;
    logic [8:0]  last_srcmap = '0;
    logic [7:0]  last_meta = '0;
    logic [15:0] last_count = '0;
    logic [31:0] mdl_cmd = '0;
    logic        mdl_pps_q = 1'b0;
    logic [15:0] mdl_live [9] = '{default: '0};
    logic [15:0] mdl_latch [9] = '{default: '0};
    int          runrst_seen = 0;

    trig_top u_trig_top (
        .sysclk_i       (sysclk_i),
        .rst_n_i        (rst_n_i),
        .sysclk_phase_i (sysclk_phase_i),
        .pps_i          (pps_i),
        .trig_dat_i     (trig_dat_i),
        .reg_adr_i      (reg_adr_i),
        .reg_dat_i      (reg_dat_i),
        .reg_we_i       (reg_we_i),
        .reg_stb_i      (reg_stb_i),
        .reg_dat_o      (reg_dat_o),
        .reg_ack_o      (reg_ack_o),
        .runrst_o       (runrst_o),
        .event_o        (event_o),
        .command_o      (command_o)
    );

    task automatic report_error(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic abort_run(input string msg);
        $display("error: %s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [15:0] surf_word();
        logic [31:0] r;
        int          pick;
        r = $urandom();
        pick = int'($urandom_range(99, 0));
        if (!surf_en) begin
            return 16'h0000;
        end
        // top bit marks a trigger request
        return {(pick < req_pct), r[14:0]};
    endfunction

    initial begin
        sysclk_i = 1'b0;
        forever #4 sysclk_i = ~sysclk_i;
    end

    initial begin : cycle_limit
        int cyc;
        cyc = 0;
        forever begin
            @(posedge sysclk_i);
            cyc++;
            if (cyc >= TIMEOUT_CYCLES) begin
                abort_run($sformatf("timeout after %0d cycles", cyc));
            end
        end
    end

    // phase pulse every 8 cycles and fresh SURF words every cycle
    initial begin : stimulus
        int ph;
        ph = 0;
        sysclk_phase_i = 1'b0;
        trig_dat_i = '0;
        forever begin
            @(posedge sysclk_i);
            #1;
            ph = (ph + 1) % 8;
            sysclk_phase_i = (ph == 0);
            for (int i = 0; i < 8; i++) begin
                trig_dat_i[i] = surf_word();
            end
        end
    end

    task automatic await_ack();
        int   n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < 8) begin
            @(negedge sysclk_i);
            n++;
            seen = reg_ack_o;
        end
        if (!seen) begin
            abort_run("register bus never acked the strobe");
        end
        assert (n == 1) else report_error($sformatf("ack came %0d cycles after strobe", n));
    endtask

    task automatic bus_write(input logic [9:0] adr, input logic [31:0] dat);
        @(posedge sysclk_i);
        #1;
        reg_adr_i = adr;
        reg_dat_i = dat;
        reg_we_i  = 1'b1;
        reg_stb_i = 1'b1;
        wr_adr    = adr;
        wr_dat    = dat;
        wr_pend   = 1'b1;
        @(posedge sysclk_i);
        #1;
        reg_we_i  = 1'b0;
        reg_stb_i = 1'b0;
        wr_pend   = 1'b0;
        await_ack();
    endtask

    task automatic bus_read(input logic [9:0] adr, output logic [31:0] dat);
        @(posedge sysclk_i);
        #1;
        reg_adr_i = adr;
        reg_we_i  = 1'b0;
        reg_stb_i = 1'b1;
        @(posedge sysclk_i);
        #1;
        reg_stb_i = 1'b0;
        await_ack();
        dat = reg_dat_o;
    endtask

    task automatic wait_frames(input int n);
        repeat (n * 8) @(posedge sysclk_i);
    endtask

    task automatic wait_cmd_op(input logic [3:0] op, input string what);
        int n;
        n = 0;
        while (command_o[31:28] !== op) begin
            if (n == 40) begin
                abort_run($sformatf("no %s command word appeared", what));
            end
            @(negedge sysclk_i);
            n++;
        end
    endtask

    task automatic pulse_pps();
        @(posedge sysclk_i);
        #1;
        pps_i = 1'b1;
        repeat (3) @(posedge sysclk_i);
        #1;
        pps_i = 1'b0;
    endtask

    // runrst and every bus ack are single-cycle pulses
    assert property (@(posedge sysclk_i) disable iff (!rst_n_i) runrst_o |=> !runrst_o)
        else report_error("runrst_o stayed high for more than one cycle");
    assert property (@(posedge sysclk_i) disable iff (!rst_n_i) reg_ack_o |=> !reg_ack_o)
        else report_error("reg_ack_o stayed high for more than one cycle");

    // reference model, compares outputs of the current cycle at the falling edge
    always @(negedge sysclk_i) begin : ref_model
        logic       sample;
        logic       accept;
        logic       found;
        logic       pps_rise;
        logic [8:0] req;
        logic [7:0] meta;
        if (rst_n_i) begin
            assert (event_o === mdl_valid)
                else report_error($sformatf("event_o %b, expected %b", event_o, mdl_valid));
            assert (runrst_o === mdl_runrst)
                else report_error($sformatf("runrst_o %b, expected %b", runrst_o, mdl_runrst));
            assert (command_o === mdl_cmd)
                else report_error($sformatf("command_o %h, expected %h", command_o, mdl_cmd));
            if (runrst_o) begin
                runrst_seen++;
            end
            // words are sampled 2 and 6 cycles after the phase pulse
            sample = (mdl_since == 2) || (mdl_since == 6);
            found = 1'b0;
            req = '0;
            meta = mdl_soft_meta;
            for (int i = 0; i < 8; i++) begin
                if (trig_dat_i[i][15] && !mdl_mask[i]) begin
                    req[i] = 1'b1;
                    if (!found) begin
                        meta = trig_dat_i[i][7:0];
                        found = 1'b1;
                    end
                end
            end
            req[8] = mdl_soft_pend;
            accept = sample && mdl_running && (mdl_hold == 16'd0) && (req != 9'd0);
            pps_rise = pps_i && !mdl_pps_q;
            mdl_pps_q = pps_i;
            for (int i = 0; i < 9; i++) begin
                if (pps_rise) begin
                    mdl_latch[i] = mdl_live[i];
                    mdl_live[i] = {15'd0, mdl_valid & mdl_srcmap[i]};
                end else if (mdl_valid && mdl_srcmap[i] && mdl_live[i] != 16'hffff) begin
                    mdl_live[i] = mdl_live[i] + 16'd1;
                end
            end
            // command word for the next frame, by priority
            if (sysclk_phase_i) begin
                if (mdl_runrst_pend) begin
                    mdl_cmd = {OP_RUNRST, 28'd0};
                    mdl_runrst_pend = 1'b0;
                end else if (mdl_runstop_pend) begin
                    mdl_cmd = {OP_RUNSTOP, 28'd0};
                    mdl_runstop_pend = 1'b0;
                end else if (mdl_trig_pend) begin
                    mdl_cmd = {OP_TRIG, last_meta, last_count[11:0],
                               last_srcmap[7:0] | {last_srcmap[8], 7'd0}};
                    mdl_trig_pend = 1'b0;
                end else begin
                    mdl_cmd = '0;
                end
            end
            if (mdl_valid) begin
                mdl_trig_pend = 1'b1;
                last_srcmap = mdl_srcmap;
                last_meta = mdl_meta;
                last_count = mdl_count;
            end
            mdl_valid = accept;
            if (accept) begin
                mdl_srcmap = req;
                mdl_meta = meta;
                mdl_count = mdl_count + 16'd1;
                mdl_hold = mdl_holdoff;
            end else if (mdl_hold != 16'd0) begin
                mdl_hold = mdl_hold - 16'd1;
            end
            if (sample) begin
                mdl_soft_pend = 1'b0;
            end
            mdl_since = sysclk_phase_i ? 1 : mdl_since + 1;
            // bus writes take effect one or two cycles after the strobe
            mdl_runrst = 1'b0;
            if (cmd_d1[0]) begin
                mdl_running = 1'b1;
                mdl_runrst = 1'b1;
                mdl_count = '0;
                mdl_runrst_pend = 1'b1;
            end
            if (cmd_d1[1]) begin
                mdl_running = 1'b0;
                mdl_runstop_pend = 1'b1;
            end
            if (soft_d1) begin
                mdl_soft_pend = 1'b1;
                mdl_soft_meta = soft_meta_d1;
            end
            cmd_d1 = '0;
            soft_d1 = 1'b0;
            if (wr_pend && wr_adr == 10'h000) begin
                cmd_d1 = wr_dat[1:0];
            end
            if (wr_pend && wr_adr == 10'h100) begin
                mdl_mask = wr_dat[7:0];
            end
            if (wr_pend && wr_adr == 10'h101) begin
                mdl_holdoff = wr_dat[15:0];
            end
            if (wr_pend && wr_adr == 10'h102) begin
                soft_d1 = 1'b1;
                soft_meta_d1 = wr_dat[7:0];
            end
        end
    end

    initial begin : main
        logic [31:0] rd;
        logic [7:0]  soft_meta;
        logic [15:0] expect_cnt;
        void'($urandom(46803));
        rst_n_i   = 1'b0;
        pps_i     = 1'b0;
        reg_adr_i = '0;
        reg_dat_i = '0;
        reg_we_i  = 1'b0;
        reg_stb_i = 1'b0;
        surf_en   = 1'b0;
        req_pct   = 0;
        wr_pend   = 1'b0;
        wr_adr    = '0;
        wr_dat    = '0;
        repeat (16) @(posedge sysclk_i);
        #1;
        rst_n_i = 1'b1;

        // reset state, then requests with no run started
        @(negedge sysclk_i);
        assert (event_o === 1'b0 && runrst_o === 1'b0 && command_o === 32'd0)
            else report_error("outputs not idle after reset");
        surf_en = 1'b1;
        req_pct = 50;
        wait_frames(6);
        bus_read(10'h000, rd);
        assert (rd[0] === 1'b0) else report_error("running set before any run-reset");

        // run-reset with zero holdoff
        surf_en = 1'b0;
        bus_write(10'h101, 32'd0);
        bus_write(10'h000, 32'd1);
        wait_cmd_op(OP_RUNRST, "run-reset");
        assert (command_o[27:0] === 28'd0) else report_error("run-reset word has nonzero fields");
        surf_en = 1'b1;
        req_pct = 30;
        wait_frames(12);
        assert (runrst_seen == 1) else report_error($sformatf("%0d runrst pulses", runrst_seen));
        bus_read(10'h000, rd);
        assert (rd[0] === 1'b1) else report_error("running not set after run-reset");

        // random masks and holdoffs
        pulse_pps();
        req_pct = 25;
        for (int k = 0; k < 6; k++) begin
            rd = $urandom();
            bus_write(10'h100, {24'd0, rd[7:0]});
            rd = $urandom_range(12, 1);
            bus_write(10'h101, rd);
            wait_frames(8);
        end
        surf_en = 1'b0;
        wait_frames(3);
        expect_cnt = mdl_count;
        bus_read(10'h103, rd);
        assert (rd === {16'd0, expect_cnt})
            else report_error($sformatf("event count %0d, expected %0d", rd, expect_cnt));

        // soft triggers carry their own metadata
        bus_write(10'h100, 32'd0);
        bus_write(10'h101, 32'd0);
        for (int k = 0; k < 3; k++) begin
            rd = $urandom();
            soft_meta = rd[7:0];
            bus_write(10'h102, {24'd0, soft_meta});
            wait_cmd_op(OP_TRIG, "soft trigger");
            assert (command_o[27:20] === soft_meta && command_o[7:0] === 8'h80)
                else report_error($sformatf("soft trigger word %h", command_o));
            wait_frames(2);
        end

        // scalers latch on pps, reserved block reads zero
        pulse_pps();
        wait_frames(1);
        for (int n = 0; n < 10; n++) begin
            bus_read(10'h300 + 10'(n), rd);
            expect_cnt = (n < 9) ? mdl_latch[n] : 16'd0;
            assert (rd === {16'd0, expect_cnt})
                else report_error($sformatf("scaler %0d read %0d, expected %0d",
                                            n, rd, expect_cnt));
        end
        bus_read(10'h2a5, rd);
        assert (rd === 32'd0) else report_error($sformatf("reserved block read %h", rd));

        // run-stop blocks further events
        bus_write(10'h000, 32'd2);
        wait_cmd_op(OP_RUNSTOP, "run-stop");
        assert (command_o[27:0] === 28'd0) else report_error("run-stop word has nonzero fields");
        surf_en = 1'b1;
        req_pct = 60;
        wait_frames(8);
        bus_read(10'h000, rd);
        assert (rd[0] === 1'b0) else report_error("running still set after run-stop");
        surf_en = 1'b0;

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+logic
logic/trig_pkg.sv
logic/reg_bus_if.sv
logic/trig_ctrl_regs.sv
logic/trig_master.sv
logic/trig_command.sv
logic/trig_scalers.sv
logic/trig_top.sv
testbench/trig_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the trigger subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --top-module trig_top_tb -f all.f -o trig_sim

# the verdict comes from the log below
./obj_dir/trig_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "^PASS: all tests$" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
